/* src/rename_pkg.sv */
// sizes, opcode enum and packed structs for the renaming core
// shared by every rtl block through scoped names
`default_nettype none

package rename_pkg;

    //////////////////////////////
    // sizes
    //////////////////////////////
    localparam int xlen       = 32;
    localparam int arch_regs  = 8;
    localparam int ar_bits    = 3;
    localparam int phys_regs  = 16;
    localparam int pr_bits    = 4;
    localparam int rob_depth  = 8;
    localparam int rob_bits   = 3;
    localparam int inq_depth  = 4;     // also the credit count after reset
    localparam int inq_bits   = 2;
    localparam int mul_stages = 3;

    //////////////////////////////
    // opcodes and packets
    //////////////////////////////
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_xor,
        op_addi,    // rs1 + sign-extended imm
        op_mul      // low 32 bits of the product
    } opcode_e;

    typedef struct packed {
        opcode_e                  op;
        logic [ar_bits-1:0]       rd;
        logic [ar_bits-1:0]       rs1;
        logic [ar_bits-1:0]       rs2;
        logic signed [15:0]       imm;
    } instr_t;

    // renamed instr with operands already read
    typedef struct packed {
        logic                     valid;
        opcode_e                  op;
        logic signed [15:0]       imm;
        logic [pr_bits-1:0]       dest_pr;
        logic [rob_bits-1:0]      rob_idx;
        logic [xlen-1:0]          src1;
        logic [xlen-1:0]          src2;
    } issue_t;

    typedef struct packed {
        logic                     valid;
        logic [pr_bits-1:0]       dest_pr;
        logic [rob_bits-1:0]      rob_idx;
        logic [xlen-1:0]          value;
    } result_t;

    typedef struct packed {
        logic                     valid;
        logic [ar_bits-1:0]       rd;     // architectural dest
        logic [xlen-1:0]          value;
    } retire_t;

endpackage

`default_nettype wire

/* src/map_table.sv */
// speculative arch-to-phys map
// three combinational lookups, one write per rename
`timescale 1ns/10ps
`default_nettype none

module map_table (
    input  wire  logic                            clock,
    input  wire  logic                            reset,
    input  wire  logic [rename_pkg::ar_bits-1:0]  map_rs1,
    input  wire  logic [rename_pkg::ar_bits-1:0]  map_rs2,
    input  wire  logic [rename_pkg::ar_bits-1:0]  map_rd,
    input  wire  logic                            map_write,
    input  wire  logic [rename_pkg::pr_bits-1:0]  free_pr,
    output logic [rename_pkg::pr_bits-1:0]        rs1_pr,
    output logic [rename_pkg::pr_bits-1:0]        rs2_pr,
    output logic [rename_pkg::pr_bits-1:0]        old_pr
);

    logic [rename_pkg::pr_bits-1:0] map [rename_pkg::arch_regs];

    // identity mapping out of reset, arch reg n lives in phys reg n
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::arch_regs; i++)
                map[i] <= rename_pkg::pr_bits'(i);
        end else if (map_write) begin
            map[map_rd] <= free_pr;
        end
    end

    // reads see the old mapping in the rename cycle, so rd == rs1 works
    assign rs1_pr = map[map_rs1];
    assign rs2_pr = map[map_rs2];
    assign old_pr = map[map_rd];       // previous owner of rd

endmodule

`default_nettype wire

/* src/free_list.sv */
// circular queue of free physical registers
// pop at rename, push of the old reg at retirement
`timescale 1ns/10ps
`default_nettype none

module free_list (
    input  wire  logic                            clock,
    input  wire  logic                            reset,
    input  wire  logic                            free_pop,
    input  wire  logic                            retire_free_valid,
    input  wire  logic [rename_pkg::pr_bits-1:0]  retire_free_pr,
    output logic [rename_pkg::pr_bits-1:0]        free_pr,
    output logic                                  free_empty
);

    logic [rename_pkg::pr_bits-1:0] fifo [rename_pkg::phys_regs];
    logic [rename_pkg::pr_bits-1:0] head, tail;
    logic [rename_pkg::pr_bits:0]   count;

    always_ff @(posedge clock) begin
        if (reset) begin
            // regs above the arch set start free, upper slots are don't care
            for (int i = 0; i < rename_pkg::phys_regs; i++)
                fifo[i] <= rename_pkg::pr_bits'(i + rename_pkg::arch_regs);
            head  <= '0;
            tail  <= rename_pkg::pr_bits'(rename_pkg::phys_regs - rename_pkg::arch_regs);
            count <= (rename_pkg::pr_bits + 1)'(rename_pkg::phys_regs - rename_pkg::arch_regs);
        end else begin
            if (retire_free_valid) begin
                fifo[tail] <= retire_free_pr;
                tail       <= tail + 1'b1;
            end
            if (free_pop) head <= head + 1'b1;
            case ({retire_free_valid, free_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    assign free_pr    = fifo[head];
    assign free_empty = (count == '0);

endmodule

`default_nettype wire

/* src/reorder_buffer.sv */
// reorder buffer, allocation at tail and retirement from head
// two completion ports mark entries done out of order
`timescale 1ns/10ps
`default_nettype none

module reorder_buffer (
    input  wire  logic                            clock,
    input  wire  logic                            reset,
    input  wire  logic                            rob_alloc,
    input  wire  logic [rename_pkg::ar_bits-1:0]  alloc_rd,
    input  wire  logic [rename_pkg::pr_bits-1:0]  alloc_old_pr,
    input  wire  rename_pkg::result_t             alu_result,
    input  wire  rename_pkg::result_t             mul_result,
    output logic [rename_pkg::rob_bits-1:0]       rob_index,
    output logic                                  rob_full,
    output rename_pkg::retire_t                   retire,
    output logic                                  retire_free_valid,
    output logic [rename_pkg::pr_bits-1:0]        retire_free_pr
);

    // entry fields
    logic                           done     [rename_pkg::rob_depth];
    logic [rename_pkg::ar_bits-1:0] rd_mem   [rename_pkg::rob_depth];
    logic [rename_pkg::pr_bits-1:0] old_mem  [rename_pkg::rob_depth];
    logic [rename_pkg::xlen-1:0]    value_mem[rename_pkg::rob_depth];

    logic [rename_pkg::rob_bits-1:0] head, tail;
    logic [rename_pkg::rob_bits:0]   count;
    logic                            retire_go;

    //////////////////////////////
    // done bits and pointers
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::rob_depth; i++)
                done[i] <= 1'b0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (rob_alloc) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (alu_result.valid) done[alu_result.rob_idx] <= 1'b1;
            if (mul_result.valid) done[mul_result.rob_idx] <= 1'b1;
            if (retire_go) head <= head + 1'b1;
            case ({rob_alloc, retire_go})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // payload
    always_ff @(posedge clock) begin
        if (rob_alloc) begin
            rd_mem[tail]  <= alloc_rd;
            old_mem[tail] <= alloc_old_pr;
        end
        if (alu_result.valid) value_mem[alu_result.rob_idx] <= alu_result.value;
        if (mul_result.valid) value_mem[mul_result.rob_idx] <= mul_result.value;
    end

    //////////////////////////////
    // alloc and retire
    //////////////////////////////
    assign rob_index = tail;
    assign rob_full  = count[rename_pkg::rob_bits];   // depth is a power of two

    // head goes the cycle after its done bit lands
    assign retire_go = (count != '0) && done[head];

    always_comb begin
        retire.valid = retire_go;
        retire.rd    = rd_mem[head];
        retire.value = value_mem[head];
    end

    assign retire_free_valid = retire_go;
    assign retire_free_pr    = old_mem[head];   // no reader of it is left

endmodule

`default_nettype wire

/* src/phys_regfile.sv */
// physical register values and ready bits
// two combinational reads, two result writes, ready clear at rename
`timescale 1ns/10ps
`default_nettype none

module phys_regfile (
    input  wire  logic                            clock,
    input  wire  logic                            reset,
    input  wire  logic [rename_pkg::pr_bits-1:0]  rd_pr_a,
    input  wire  logic [rename_pkg::pr_bits-1:0]  rd_pr_b,
    output logic [rename_pkg::xlen-1:0]           rd_value_a,
    output logic [rename_pkg::xlen-1:0]           rd_value_b,
    output logic                                  rd_ready_a,
    output logic                                  rd_ready_b,
    input  wire  logic                            clear_ready,
    input  wire  logic [rename_pkg::pr_bits-1:0]  clear_pr,
    input  wire  rename_pkg::result_t             alu_result,
    input  wire  rename_pkg::result_t             mul_result
);

    logic [rename_pkg::xlen-1:0] values [rename_pkg::phys_regs];
    logic                        ready  [rename_pkg::phys_regs];

    always_ff @(posedge clock) begin
        if (reset) begin
            // arch regs start at zero and ready
            for (int i = 0; i < rename_pkg::phys_regs; i++) begin
                values[i] <= '0;
                ready[i]  <= 1'b1;
            end
        end else begin
            if (clear_ready) ready[clear_pr] <= 1'b0;   // never a reg being written
            if (alu_result.valid) begin
                values[alu_result.dest_pr] <= alu_result.value;
                ready[alu_result.dest_pr]  <= 1'b1;
            end
            if (mul_result.valid) begin
                values[mul_result.dest_pr] <= mul_result.value;
                ready[mul_result.dest_pr]  <= 1'b1;
            end
        end
    end

    // no bypass, dependents see the value the cycle after the write
    assign rd_value_a = values[rd_pr_a];
    assign rd_value_b = values[rd_pr_b];
    assign rd_ready_a = ready[rd_pr_a];
    assign rd_ready_b = ready[rd_pr_b];

endmodule

`default_nettype wire

/* src/exec_unit.sv */
// single-cycle alu and pipelined multiplier
// each drives its own completion bus
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
    input  wire  logic                clock,
    input  wire  logic                reset,
    input  wire  rename_pkg::issue_t  issue,
    output rename_pkg::result_t       alu_result,
    output rename_pkg::result_t       mul_result
);

    logic [rename_pkg::xlen-1:0] imm_ext;
    logic [rename_pkg::xlen-1:0] alu_value;
    rename_pkg::result_t         mul_pipe [rename_pkg::mul_stages];

    assign imm_ext = {{(rename_pkg::xlen - 16){issue.imm[15]}}, issue.imm};

    //////////////////////////////
    // alu
    //////////////////////////////
    always_comb begin
        case (issue.op)
            rename_pkg::op_add:  alu_value = issue.src1 + issue.src2;
            rename_pkg::op_sub:  alu_value = issue.src1 - issue.src2;
            rename_pkg::op_and:  alu_value = issue.src1 & issue.src2;
            rename_pkg::op_xor:  alu_value = issue.src1 ^ issue.src2;
            rename_pkg::op_addi: alu_value = issue.src1 + imm_ext;
            default:             alu_value = '0;   // mul goes the other way
        endcase
    end

    // result valid the cycle after issue
    always_ff @(posedge clock) begin
        if (reset) begin
            alu_result.valid <= 1'b0;
        end else begin
            alu_result.valid   <= issue.valid && (issue.op != rename_pkg::op_mul);
            alu_result.dest_pr <= issue.dest_pr;
            alu_result.rob_idx <= issue.rob_idx;
            alu_result.value   <= alu_value;
        end
    end

    //////////////////////////////
    // multiplier
    //////////////////////////////
    // product enters stage 0, valid tag shifts with it, one new mul per cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::mul_stages; i++)
                mul_pipe[i].valid <= 1'b0;
        end else begin
            mul_pipe[0].valid   <= issue.valid && (issue.op == rename_pkg::op_mul);
            mul_pipe[0].dest_pr <= issue.dest_pr;
            mul_pipe[0].rob_idx <= issue.rob_idx;
            mul_pipe[0].value   <= issue.src1 * issue.src2;   // low half only
            for (int i = 1; i < rename_pkg::mul_stages; i++)
                mul_pipe[i] <= mul_pipe[i - 1];
        end
    end

    assign mul_result = mul_pipe[rename_pkg::mul_stages - 1];   // three cycles after issue

endmodule

`default_nettype wire

/* src/dispatch_ctrl.sv */
// input queue with credit return
// in-order rename and issue, one per cycle, stalls on operands or resources
`timescale 1ns/10ps
`default_nettype none

module dispatch_ctrl (
    input  wire  logic                            clock,
    input  wire  logic                            reset,
    input  wire  logic                            instr_valid,
    input  wire  rename_pkg::instr_t              instr,
    output logic                                  credit_return,
    output logic [rename_pkg::ar_bits-1:0]        map_rs1,
    output logic [rename_pkg::ar_bits-1:0]        map_rs2,
    output logic [rename_pkg::ar_bits-1:0]        map_rd,
    input  wire  logic [rename_pkg::pr_bits-1:0]  rs1_pr,
    input  wire  logic [rename_pkg::pr_bits-1:0]  rs2_pr,
    input  wire  logic [rename_pkg::pr_bits-1:0]  old_pr,
    output logic                                  map_write,
    output logic [rename_pkg::pr_bits-1:0]        read_pr1,
    output logic [rename_pkg::pr_bits-1:0]        read_pr2,
    output logic [rename_pkg::pr_bits-1:0]        alloc_old_pr,
    input  wire  logic [rename_pkg::pr_bits-1:0]  free_pr,
    input  wire  logic                            free_empty,
    output logic                                  free_pop,
    input  wire  logic                            rob_full,
    output logic                                  rob_alloc,
    input  wire  logic [rename_pkg::rob_bits-1:0] rob_index,
    input  wire  logic                            rs1_ready,
    input  wire  logic                            rs2_ready,
    input  wire  logic [rename_pkg::xlen-1:0]     rs1_value,
    input  wire  logic [rename_pkg::xlen-1:0]     rs2_value,
    output logic                                  clear_ready,
    output rename_pkg::issue_t                    issue
);

    rename_pkg::instr_t                   queue [rename_pkg::inq_depth];
    logic [rename_pkg::inq_bits-1:0]      q_head, q_tail;
    logic [rename_pkg::inq_bits:0]        q_count;
    rename_pkg::instr_t                   head_instr;
    logic                                 do_issue;

    //////////////////////////////
    // input queue
    //////////////////////////////
    // credits keep the source from ever overfilling this
    always_ff @(posedge clock) begin
        if (instr_valid)
            queue[q_tail] <= instr;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            q_head  <= '0;
            q_tail  <= '0;
            q_count <= '0;
        end else begin
            if (instr_valid) q_tail <= q_tail + 1'b1;
            if (do_issue)    q_head <= q_head + 1'b1;
            case ({instr_valid, do_issue})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: ;   // both or neither, count holds
            endcase
        end
    end

    //////////////////////////////
    // rename / issue decision
    //////////////////////////////
    assign head_instr = queue[q_head];

    // lookups always follow the queue head
    assign map_rs1      = head_instr.rs1;
    assign map_rs2      = head_instr.rs2;
    assign map_rd       = head_instr.rd;
    assign read_pr1     = rs1_pr;      // regfile operand ports
    assign read_pr2     = rs2_pr;
    assign alloc_old_pr = old_pr;      // freed when this instr retires

    // data stall on either source, structural stall on rob or free list
    assign do_issue = (q_count != '0) && rs1_ready && rs2_ready
                      && !rob_full && !free_empty;

    // every side effect of a rename fires together
    assign map_write     = do_issue;
    assign free_pop      = do_issue;
    assign rob_alloc     = do_issue;
    assign clear_ready   = do_issue;
    assign credit_return = do_issue;   // slot leaves the queue this cycle

    always_comb begin
        issue.valid   = do_issue;
        issue.op      = head_instr.op;
        issue.imm     = head_instr.imm;
        issue.dest_pr = free_pr;       // same reg the map table takes
        issue.rob_idx = rob_index;
        issue.src1    = rs1_value;
        issue.src2    = rs2_value;
    end

endmodule

`default_nettype wire

/* src/rename_core.sv */
// top level of the renaming core
// control block plus map table, free list, rob, regfile, exec unit
`timescale 1ns/10ps
`default_nettype none

module rename_core (
    input  wire  logic                clock,
    input  wire  logic                reset,
    input  wire  logic                instr_valid,
    input  wire  rename_pkg::instr_t  instr,
    output logic                      credit_return,
    output rename_pkg::retire_t       retire
);

    // rename lookups
    logic [rename_pkg::ar_bits-1:0]   map_rs1, map_rs2, map_rd;
    logic [rename_pkg::pr_bits-1:0]   rs1_pr, rs2_pr, old_pr;
    logic [rename_pkg::pr_bits-1:0]   read_pr1, read_pr2, alloc_old_pr;
    logic                             map_write;

    // free list
    logic [rename_pkg::pr_bits-1:0]   free_pr;
    logic                             free_empty, free_pop;
    logic                             retire_free_valid;
    logic [rename_pkg::pr_bits-1:0]   retire_free_pr;

    // rob alloc
    logic                             rob_full, rob_alloc;
    logic [rename_pkg::rob_bits-1:0]  rob_index;

    // operands and completion
    logic                             rs1_ready, rs2_ready, clear_ready;
    logic [rename_pkg::xlen-1:0]      rs1_value, rs2_value;
    rename_pkg::issue_t               issue;
    rename_pkg::result_t              alu_result, mul_result;

    dispatch_ctrl u_dispatch (
        .clock(clock), .reset(reset),
        .instr_valid(instr_valid), .instr(instr), .credit_return(credit_return),
        .map_rs1(map_rs1), .map_rs2(map_rs2), .map_rd(map_rd),
        .rs1_pr(rs1_pr), .rs2_pr(rs2_pr), .old_pr(old_pr), .map_write(map_write),
        .read_pr1(read_pr1), .read_pr2(read_pr2), .alloc_old_pr(alloc_old_pr),
        .free_pr(free_pr), .free_empty(free_empty), .free_pop(free_pop),
        .rob_full(rob_full), .rob_alloc(rob_alloc), .rob_index(rob_index),
        .rs1_ready(rs1_ready), .rs2_ready(rs2_ready),
        .rs1_value(rs1_value), .rs2_value(rs2_value), .clear_ready(clear_ready),
        .issue(issue)
    );

    map_table u_map (
        .clock(clock), .reset(reset),
        .map_rs1(map_rs1), .map_rs2(map_rs2), .map_rd(map_rd),
        .map_write(map_write), .free_pr(free_pr),
        .rs1_pr(rs1_pr), .rs2_pr(rs2_pr), .old_pr(old_pr)
    );

    free_list u_free (
        .clock(clock), .reset(reset), .free_pop(free_pop),
        .retire_free_valid(retire_free_valid), .retire_free_pr(retire_free_pr),
        .free_pr(free_pr), .free_empty(free_empty)
    );

    reorder_buffer u_rob (
        .clock(clock), .reset(reset), .rob_alloc(rob_alloc),
        .alloc_rd(map_rd), .alloc_old_pr(alloc_old_pr),
        .alu_result(alu_result), .mul_result(mul_result),
        .rob_index(rob_index), .rob_full(rob_full), .retire(retire),
        .retire_free_valid(retire_free_valid), .retire_free_pr(retire_free_pr)
    );

    phys_regfile u_prf (
        .clock(clock), .reset(reset),
        .rd_pr_a(read_pr1), .rd_pr_b(read_pr2),
        .rd_value_a(rs1_value), .rd_value_b(rs2_value),
        .rd_ready_a(rs1_ready), .rd_ready_b(rs2_ready),
        .clear_ready(clear_ready), .clear_pr(free_pr),   // new dest goes not-ready
        .alu_result(alu_result), .mul_result(mul_result)
    );

    exec_unit u_exec (
        .clock(clock), .reset(reset), .issue(issue),
        .alu_result(alu_result), .mul_result(mul_result)
    );

endmodule

`default_nettype wire

/* testbench/tb_rename_core.sv */
// testbench for the renaming core
// reads the pattern file, drives instructions under credit control,
// checks retirements in order, credits and reset state
`timescale 1ns/10ps
`default_nettype none

module tb_rename_core;

    logic                 clock = 1'b0;      // starts low, no edge at time zero
    logic                 reset;
    logic                 instr_valid;
    rename_pkg::instr_t   instr;
    logic                 credit_return;
    rename_pkg::retire_t  retire;

    // pattern storage, one entry per instruction
    string                pat_test [$];
    rename_pkg::instr_t   pat_instr [$];
    logic [31:0]          pat_expect [$];

    int  pat_count         = 0;
    int  ret_idx           = 0;   // next expected retirement
    int  sent_count        = 0;
    int  returned_count    = 0;   // credit_return pulses seen
    int  cycle_count       = 0;
    int  cycle_limit       = 0;
    int  post_reset_cycles = 0;
    int  error_count       = 0;
    int  check_count       = 0;
    int  test_count        = 0;
    int  test_errors       = 0;
    int  test_checks       = 0;
    bit  patterns_loaded   = 1'b0;

    rename_core uut (
        .clock(clock), .reset(reset),
        .instr_valid(instr_valid), .instr(instr),
        .credit_return(credit_return), .retire(retire)
    );

    initial begin
        forever #10 clock = ~clock;   // 20 ns period
    end

    //////////////////////////////
    // helpers
    //////////////////////////////
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        test_checks++;
        if (actual !== expected) begin
            $display("Error: test %s expected %h actual %h", name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    // one report line per finished test
    task automatic finish_test(input string name);
        if (test_errors == 0)
            $display("test %s ok, %0d checks", name, test_checks);
        else
            $display("test %s has %0d errors in %0d checks", name, test_errors, test_checks);
        test_count++;
        test_errors = 0;
        test_checks = 0;
    endtask

    function automatic bit op_lookup(input string name, output rename_pkg::opcode_e op);
        op = rename_pkg::op_add;
        case (name)
            "add":   op = rename_pkg::op_add;
            "sub":   op = rename_pkg::op_sub;
            "and":   op = rename_pkg::op_and;
            "xor":   op = rename_pkg::op_xor;
            "addi":  op = rename_pkg::op_addi;
            "mul":   op = rename_pkg::op_mul;
            default: return 1'b0;   // unknown mnemonic
        endcase
        return 1'b1;
    endfunction

    task automatic load_patterns(output bit ok);
        int                   fd;
        int                   fields;
        int                   rd, rs1, rs2, imm;
        logic [31:0]          expected;
        string                line, tname, opname;
        rename_pkg::instr_t   ins;
        rename_pkg::opcode_e  op;
        ok = 1'b0;
        fd = $fopen("testbench/rename_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/rename_patterns.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#")
                continue;                              // blank or comment
            fields = $sscanf(line, "%s %s %d %d %d %d %h",
                             tname, opname, rd, rs1, rs2, imm, expected);
            if (fields != 7 || !op_lookup(opname, op)) begin
                $display("pattern line could not be parsed: %s", line);
                error_count++;
                continue;
            end
            ins.op  = op;
            ins.rd  = rename_pkg::ar_bits'(rd);
            ins.rs1 = rename_pkg::ar_bits'(rs1);
            ins.rs2 = rename_pkg::ar_bits'(rs2);
            ins.imm = 16'(imm);                        // keeps the sign bits
            pat_test.push_back(tname);
            pat_instr.push_back(ins);
            pat_expect.push_back(expected);
        end
        $fclose(fd);
        pat_count = pat_test.size();
        ok = (pat_count > 0);
    endtask

    // waits for a credit, then holds instr_valid for one cycle
    task automatic send_instr(input int idx);
        while (rename_pkg::inq_depth - sent_count + returned_count <= 0) begin
            @(posedge clock);
            #1;
        end
        instr_valid = 1'b1;
        instr       = pat_instr[idx];
        sent_count++;
        @(posedge clock);
        #1;
        instr_valid = 1'b0;
    endtask

    //////////////////////////////
    // monitors, sampled mid-cycle
    //////////////////////////////
    always @(negedge clock) begin : monitor
        int credits;
        if (credit_return)
            returned_count++;
        credits = rename_pkg::inq_depth - sent_count + returned_count;
        if (credits < 0 || credits > rename_pkg::inq_depth) begin
            $display("credit count left its range, source holds %0d credits", credits);
            error_count++;
            test_errors++;
        end

        // quiet outputs in reset and the first cycle after it
        if (reset || post_reset_cycles == 0) begin
            check_value("reset", 32'd0, 32'(credit_return));
            check_value("reset", 32'd0, 32'(retire.valid));
            if (!reset)
                finish_test("reset");
        end
        if (!reset)
            post_reset_cycles++;

        if (!reset && retire.valid) begin
            if (ret_idx >= pat_count) begin
                $display("retirement of r%0d came after the last pattern", retire.rd);
                error_count++;
            end else begin
                check_value({pat_test[ret_idx], " rd"},
                            32'(pat_instr[ret_idx].rd), 32'(retire.rd));
                check_value(pat_test[ret_idx], pat_expect[ret_idx], retire.value);
                ret_idx++;
                // test ends with its last retirement
                if (ret_idx == pat_count || pat_test[ret_idx] != pat_test[ret_idx - 1])
                    finish_test(pat_test[ret_idx - 1]);
            end
        end
    end

    // run limit grows with the pattern count
    always @(posedge clock) begin
        cycle_count++;
        if (patterns_loaded && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, only %0d of %0d instructions retired",
                     cycle_count, ret_idx, pat_count);
            $display("Simulation failed");
            $finish;
        end
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin : main
        bit loaded;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        load_patterns(loaded);
        if (!loaded) begin
            $display("no usable pattern lines were read");
            $display("Simulation failed");
            $finish;
        end else begin
            cycle_limit     = 20 * pat_count + 100;
            patterns_loaded = 1'b1;
            repeat (3) @(posedge clock);   // reset over three edges
            #1 reset = 1'b0;
            for (int i = 0; i < pat_count; i++)
                send_instr(i);
            wait (ret_idx == pat_count);
            repeat (2) @(negedge clock);   // let late credit pulses land

            // every queue slot comes back
            check_value("credits", 32'(sent_count), 32'(returned_count));
            check_value("credits", 32'(rename_pkg::inq_depth),
                        32'(rename_pkg::inq_depth - sent_count + returned_count));
            finish_test("credits");

            $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
            if (error_count == 0)
                $display("Simulation completed successfully");
            else
                $display("Simulation failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* testbench/rename_patterns.txt */
# columns: test op rd rs1 rs2 imm expected_hex
# expected is the value retired to rd, all arch regs start at zero
indep addi 1 0 0 5 00000005
indep addi 2 0 0 -3 fffffffd
indep addi 3 0 0 12 0000000c
indep xor 4 1 3 0 00000009
indep and 5 1 3 0 00000004
indep add 6 2 3 0 00000009
chain addi 7 0 0 100 00000064
chain add 7 7 7 0 000000c8
chain sub 6 7 1 0 000000c3
chain sub 5 5 7 0 ffffff3c
ooo mul 1 3 7 0 00000960
ooo addi 2 0 0 7 00000007
ooo add 4 3 3 0 00000018
ooo mul 3 2 2 0 00000031
ooo add 6 1 4 0 00000978
recycle addi 1 1 0 1 00000961
recycle addi 2 2 0 2 00000009
recycle addi 1 1 0 1 00000962
recycle addi 2 2 0 2 0000000b
recycle addi 1 1 0 1 00000963
recycle addi 2 2 0 2 0000000d
recycle addi 1 1 0 1 00000964
recycle addi 2 2 0 2 0000000f
recycle addi 1 1 0 1 00000965
recycle addi 2 2 0 2 00000011
recycle addi 1 1 0 1 00000966
recycle addi 2 2 0 2 00000013
recycle addi 1 1 0 1 00000967
recycle addi 2 2 0 2 00000015
recycle addi 1 1 0 1 00000968
recycle addi 2 2 0 2 00000017
recycle sub 1 1 2 0 00000951

/* sources.f */
src/rename_pkg.sv
src/map_table.sv
src/free_list.sv
src/reorder_buffer.sv
src/phys_regfile.sv
src/exec_unit.sv
src/dispatch_ctrl.sv
src/rename_core.sv
testbench/tb_rename_core.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it, decide pass or fail from the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f sources.f \
    --top-module tb_rename_core -Mdir obj_dir -o sim_rename_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_rename_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation completed successfully$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
